// ==== logic/c0_read_request_checker.sv ====
/*
 * C0 read request checker
 * Flags illegal types, 3-line reads, misaligned bursts and overflow
 */

`include "ccip_checker_settings.svh"

module c0_read_request_checker (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        c0_valid,
   input  ccip_checker_pkg::req_type_e c0_req_type,
   input  ccip_checker_pkg::cl_len_e   c0_len,
   input  ccip_checker_pkg::cl_addr_t  c0_addr,
   input  logic                        c0_realfull,
   output logic                        c0_illegal_type,
   output logic                        c0_illegal_len,
   output logic                        c0_misaligned,
   output logic                        c0_overflow
);

   import ccip_checker_pkg::*;

   logic is_read;
   logic bad_len;
   logic bad_align;

   // Only the two read flavours belong on C0
   assign is_read = (c0_req_type == RDLINE_I) || (c0_req_type == RDLINE_S);

   // 3-line requests are not defined
   assign bad_len = (c0_len == CL_3);

   // Multi-line base must sit on a burst boundary
   always_comb begin
      bad_align = 1'b0;
      if (c0_len == CL_2) begin
         bad_align = c0_addr[0];
      end else if (c0_len == CL_4) begin
         bad_align = (c0_addr[1:0] != 2'b00);
      end
   end

   // One-cycle flags, one stage behind the request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         c0_illegal_type <= 1'b0;
         c0_illegal_len  <= 1'b0;
         c0_misaligned   <= 1'b0;
         c0_overflow     <= 1'b0;
      end else begin
         c0_illegal_type <= c0_valid && !is_read;
         // Length and alignment only judged on real reads
         c0_illegal_len  <= c0_valid && is_read && bad_len;
         c0_misaligned   <= c0_valid && is_read && bad_align;
         // Pushed into a full port, request likely lost
         c0_overflow     <= c0_valid && c0_realfull;
      end
   end

   // A bad type masks the length and alignment checks
   a_c0_type_excl : assert property (@(posedge clk) disable iff (!rst_n)
      c0_illegal_type |-> !(c0_illegal_len || c0_misaligned));

endmodule

// ==== logic/c1_write_beat_checker.sv ====
/*
 * C1 write checker
 * Tracks multi-line write beats against the captured first beat
 * and flags type, length, alignment and overflow violations
 */

`include "ccip_checker_settings.svh"

module c1_write_beat_checker (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        c1_valid,
   input  ccip_checker_pkg::req_type_e c1_req_type,
   input  ccip_checker_pkg::cl_len_e   c1_len,
   input  logic                        c1_sop,
   input  ccip_checker_pkg::cl_addr_t  c1_addr,
   input  ccip_checker_pkg::vc_t       c1_vc,
   input  ccip_checker_pkg::mdata_t    c1_mdata,
   input  logic                        c1_realfull,
   output logic                        c1_illegal_type,
   output logic                        c1_illegal_len,
   output logic                        c1_misaligned,
   output logic                        c1_sop_error,
   output logic                        c1_addr_error,
   output logic                        c1_vc_error,
   output logic                        c1_mdata_warn,
   output logic                        c1_overflow
);

   import ccip_checker_pkg::*;

   beat_state_e beat_state;
   beat_state_e beat_state_next;

   // First beat snapshot
   cl_addr_t base_addr;
   vc_t      cap_vc;
   mdata_t   cap_mdata;
   cl_len_e  cap_len;

   logic     wr_type;
   logic     legal_type;
   logic     is_write;
   logic     burst_start;
   logic     last_beat;
   cl_addr_t expected_addr;

   logic     illegal_len_d;
   logic     misaligned_d;
   logic     sop_error_d;
   logic     addr_error_d;
   logic     vc_error_d;
   logic     mdata_warn_d;

   assign wr_type    = (c1_req_type == WRLINE_I) || (c1_req_type == WRLINE_M);
   assign legal_type = wr_type || (c1_req_type == WRFENCE);
   // Fences and other non-writes do not move the beat tracker
   assign is_write   = c1_valid && wr_type;

   // SOP beat of a 2 or 4 line burst
   assign burst_start = is_write && (beat_state == BEAT_1) && c1_sop &&
                        ((c1_len == CL_2) || (c1_len == CL_4));

   // Beat k expects base + k - 1, state code is k - 1
   assign expected_addr = base_addr + cl_addr_t'(beat_state);

   assign last_beat = (beat_state == BEAT_4) ||
                      ((beat_state == BEAT_2) && (cap_len == CL_2));

   // Beat decode and next state
   always_comb begin
      beat_state_next = beat_state;
      illegal_len_d   = 1'b0;
      misaligned_d    = 1'b0;
      sop_error_d     = 1'b0;
      addr_error_d    = 1'b0;
      vc_error_d      = 1'b0;
      mdata_warn_d    = 1'b0;
      if (is_write) begin
         if (beat_state == BEAT_1) begin
            if (!c1_sop) begin
               // First line must carry SOP, nothing starts
               sop_error_d = 1'b1;
            end else if (c1_len == CL_3) begin
               illegal_len_d = 1'b1;
            end else if (burst_start) begin
               // Misaligned base is flagged but burst still tracked
               if (c1_len == CL_2) begin
                  misaligned_d = c1_addr[0];
               end else begin
                  misaligned_d = (c1_addr[1:0] != 2'b00);
               end
               beat_state_next = BEAT_2;
            end
         end else begin
            sop_error_d  = c1_sop;
            addr_error_d = (c1_addr != expected_addr);
            vc_error_d   = (c1_vc != cap_vc);
            // Only first beat MDATA is used, so just a warning
            mdata_warn_d = (c1_mdata != cap_mdata);
            if (last_beat) begin
               beat_state_next = BEAT_1;
            end else if (beat_state == BEAT_2) begin
               beat_state_next = BEAT_3;
            end else begin
               beat_state_next = BEAT_4;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         beat_state <= BEAT_1;
      end else begin
         beat_state <= beat_state_next;
      end
   end

   // Burst header capture
   always_ff @(posedge clk) begin
      if (burst_start) begin
         base_addr <= c1_addr;
         cap_vc    <= c1_vc;
         cap_mdata <= c1_mdata;
         cap_len   <= c1_len;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         c1_illegal_type <= 1'b0;
         c1_illegal_len  <= 1'b0;
         c1_misaligned   <= 1'b0;
         c1_sop_error    <= 1'b0;
         c1_addr_error   <= 1'b0;
         c1_vc_error     <= 1'b0;
         c1_mdata_warn   <= 1'b0;
         c1_overflow     <= 1'b0;
      end else begin
         c1_illegal_type <= c1_valid && !legal_type;
         c1_illegal_len  <= illegal_len_d;
         c1_misaligned   <= misaligned_d;
         c1_sop_error    <= sop_error_d;
         c1_addr_error   <= addr_error_d;
         c1_vc_error     <= vc_error_d;
         c1_mdata_warn   <= mdata_warn_d;
         c1_overflow     <= c1_valid && c1_realfull;
      end
   end

   // Two-line burst ends after beat 2
   a_c1_no_beat3_cl2 : assert property (@(posedge clk) disable iff (!rst_n)
      !((beat_state == BEAT_3) && (cap_len == CL_2)));

   // Address errors come only from a later beat of a burst
   a_c1_addr_err_src : assert property (@(posedge clk) disable iff (!rst_n)
      c1_addr_error |-> $past(is_write && (beat_state != BEAT_1)));

endmodule

// ==== logic/ccip_checker_pkg.sv ====
/*
 * CCI-P protocol checker types
 * Header field vectors, request and length encodings, C1 beat states
 */

`include "ccip_checker_settings.svh"

package ccip_checker_pkg;

   // Cache-line address
   typedef logic [`CCIP_ADDR_WIDTH-1:0] cl_addr_t;

   // Request metadata, returned with the response
   typedef logic [`CCIP_MDATA_WIDTH-1:0] mdata_t;

   // MMIO transaction ID
   typedef logic [`CCIP_TID_WIDTH-1:0] mmio_tid_t;

   // Virtual channel select
   typedef logic [1:0] vc_t;

   // Number of lines minus one
   typedef enum logic [1:0] {
      CL_1 = 2'd0,
      CL_2 = 2'd1,
      CL_3 = 2'd2,
      CL_4 = 2'd3
   } cl_len_e;

   // Request type field, other codes are illegal
   typedef enum logic [3:0] {
      RDLINE_I = 4'h0,
      RDLINE_S = 4'h1,
      WRLINE_I = 4'h2,
      WRLINE_M = 4'h3,
      WRFENCE  = 4'h4
   } req_type_e;

   // Expected beat of a multi-line write
   typedef enum logic [1:0] {
      BEAT_1 = 2'd0,
      BEAT_2 = 2'd1,
      BEAT_3 = 2'd2,
      BEAT_4 = 2'd3
   } beat_state_e;

endpackage

// ==== logic/ccip_checker_settings.svh ====
/*
 * CCI-P protocol checker settings
 * Field widths and the MMIO read response timeout
 */

`ifndef CCIP_CHECKER_SETTINGS_SVH
`define CCIP_CHECKER_SETTINGS_SVH

// Cache-line address width
`define CCIP_ADDR_WIDTH 42

// Request metadata width
`define CCIP_MDATA_WIDTH 16

// MMIO transaction ID width
`define CCIP_TID_WIDTH 9

// MMIO read must be answered within this many cycles
`define MMIO_TIMEOUT_CYCLES 512
// Counter width, must hold MMIO_TIMEOUT_CYCLES
`define MMIO_COUNT_WIDTH 10

`endif

// ==== logic/ccip_protocol_checker.sv ====
/*
 * CCI-P protocol checker top
 * Fans the request and MMIO ports out to the three checkers
 */

`include "ccip_checker_settings.svh"

module ccip_protocol_checker (
   input  logic                        clk,
   input  logic                        rst_n,
   // Channel 0 read requests
   input  logic                        c0_valid,
   input  ccip_checker_pkg::req_type_e c0_req_type,
   input  ccip_checker_pkg::cl_len_e   c0_len,
   input  ccip_checker_pkg::cl_addr_t  c0_addr,
   input  logic                        c0_realfull,
   // Channel 1 write requests
   input  logic                        c1_valid,
   input  ccip_checker_pkg::req_type_e c1_req_type,
   input  ccip_checker_pkg::cl_len_e   c1_len,
   input  logic                        c1_sop,
   input  ccip_checker_pkg::cl_addr_t  c1_addr,
   input  ccip_checker_pkg::vc_t       c1_vc,
   input  ccip_checker_pkg::mdata_t    c1_mdata,
   input  logic                        c1_realfull,
   // MMIO read request and response
   input  logic                        mmio_rd_valid,
   input  ccip_checker_pkg::mmio_tid_t mmio_rd_tid,
   input  logic                        mmio_rsp_valid,
   input  ccip_checker_pkg::mmio_tid_t mmio_rsp_tid,
   // C0 flags
   output logic                        c0_illegal_type,
   output logic                        c0_illegal_len,
   output logic                        c0_misaligned,
   output logic                        c0_overflow,
   // C1 flags
   output logic                        c1_illegal_type,
   output logic                        c1_illegal_len,
   output logic                        c1_misaligned,
   output logic                        c1_sop_error,
   output logic                        c1_addr_error,
   output logic                        c1_vc_error,
   output logic                        c1_mdata_warn,
   output logic                        c1_overflow,
   // MMIO flags, timeout is a level
   output logic                        mmio_timeout,
   output logic                        mmio_unsolicited,
   output logic                        mmio_tid_mismatch
);

   import ccip_checker_pkg::*;

   c0_read_request_checker c0_read_request_checker_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .c0_valid        (c0_valid),
      .c0_req_type     (c0_req_type),
      .c0_len          (c0_len),
      .c0_addr         (c0_addr),
      .c0_realfull     (c0_realfull),
      .c0_illegal_type (c0_illegal_type),
      .c0_illegal_len  (c0_illegal_len),
      .c0_misaligned   (c0_misaligned),
      .c0_overflow     (c0_overflow)
   );

   c1_write_beat_checker c1_write_beat_checker_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .c1_valid        (c1_valid),
      .c1_req_type     (c1_req_type),
      .c1_len          (c1_len),
      .c1_sop          (c1_sop),
      .c1_addr         (c1_addr),
      .c1_vc           (c1_vc),
      .c1_mdata        (c1_mdata),
      .c1_realfull     (c1_realfull),
      .c1_illegal_type (c1_illegal_type),
      .c1_illegal_len  (c1_illegal_len),
      .c1_misaligned   (c1_misaligned),
      .c1_sop_error    (c1_sop_error),
      .c1_addr_error   (c1_addr_error),
      .c1_vc_error     (c1_vc_error),
      .c1_mdata_warn   (c1_mdata_warn),
      .c1_overflow     (c1_overflow)
   );

   mmio_read_tracker mmio_read_tracker_inst (
      .clk               (clk),
      .rst_n             (rst_n),
      .mmio_rd_valid     (mmio_rd_valid),
      .mmio_rd_tid       (mmio_rd_tid),
      .mmio_rsp_valid    (mmio_rsp_valid),
      .mmio_rsp_tid      (mmio_rsp_tid),
      .mmio_timeout      (mmio_timeout),
      .mmio_unsolicited  (mmio_unsolicited),
      .mmio_tid_mismatch (mmio_tid_mismatch)
   );

endmodule

// ==== logic/mmio_read_tracker.sv ====
/*
 * MMIO read tracker
 * Follows one outstanding MMIO read, flags timeout,
 * unsolicited responses and TID mismatch
 */

`include "ccip_checker_settings.svh"

module mmio_read_tracker (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        mmio_rd_valid,
   input  ccip_checker_pkg::mmio_tid_t mmio_rd_tid,
   input  logic                        mmio_rsp_valid,
   input  ccip_checker_pkg::mmio_tid_t mmio_rsp_tid,
   output logic                        mmio_timeout,
   output logic                        mmio_unsolicited,
   output logic                        mmio_tid_mismatch
);

   import ccip_checker_pkg::*;

   localparam logic [`MMIO_COUNT_WIDTH-1:0] TIMEOUT_LIMIT =
      `MMIO_COUNT_WIDTH'(`MMIO_TIMEOUT_CYCLES);

   logic                         outstanding;
   logic                         rsp_close;
   logic                         rd_open;
   mmio_tid_t                    cap_tid;
   logic [`MMIO_COUNT_WIDTH-1:0] timeout_count;

   // Response wins when both arrive together
   assign rsp_close = mmio_rsp_valid && outstanding;
   assign rd_open   = mmio_rd_valid && !mmio_rsp_valid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         outstanding <= 1'b0;
      end else if (rsp_close) begin
         outstanding <= 1'b0;
      end else if (rd_open) begin
         outstanding <= 1'b1;
      end
   end

   // Latest request TID is the one expected back
   always_ff @(posedge clk) begin
      if (rd_open) begin
         cap_tid <= mmio_rd_tid;
      end
   end

   // Wait counter, saturates at the limit
   // A second request keeps the running count
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         timeout_count <= '0;
      end else if (rsp_close) begin
         timeout_count <= '0;
      end else if (outstanding && (timeout_count != TIMEOUT_LIMIT)) begin
         timeout_count <= timeout_count + 1'b1;
      end
   end

   // Level, held until the response closes the read
   assign mmio_timeout = (timeout_count == TIMEOUT_LIMIT);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mmio_unsolicited  <= 1'b0;
         mmio_tid_mismatch <= 1'b0;
      end else begin
         mmio_unsolicited  <= mmio_rsp_valid && !outstanding;
         mmio_tid_mismatch <= rsp_close && (mmio_rsp_tid != cap_tid);
      end
   end

   // Idle tracker never holds a stale count
   a_mmio_idle_count : assert property (@(posedge clk) disable iff (!rst_n)
      !outstanding |-> (timeout_count == '0));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the CCI-P checker testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module tb_ccip_protocol_checker -o tb_ccip_protocol_checker
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_output=$(./obj_dir/tb_ccip_protocol_checker)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== sim.f ====
+incdir+logic
logic/ccip_checker_pkg.sv
logic/c0_read_request_checker.sv
logic/c1_write_beat_checker.sv
logic/mmio_read_tracker.sv
logic/ccip_protocol_checker.sv
testbench/tb_clock_gen.sv
testbench/tb_ccip_protocol_checker.sv

// ==== testbench/tb_ccip_protocol_checker.sv ====
/*
 * CCI-P protocol checker testbench
 * Drives legal and faulty C0, C1 and MMIO traffic into the DUT, a reference
 * model predicts every flag and assertions compare the two each cycle
 */

`include "ccip_checker_settings.svh"

module tb_ccip_protocol_checker;

   timeunit 1ns;
   timeprecision 1ps;

   import ccip_checker_pkg::*;

   localparam int TIMEOUT_CYCLES  = `MMIO_TIMEOUT_CYCLES;
   // Reset, legal traffic, C0 errors, C1 errors, MMIO errors, overflow
   localparam int TEST_CYCLES     = 16 + 100 + 40 + 50 + (TIMEOUT_CYCLES + 40) + 20;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + 2000;

   logic      clk;
   logic      rst_n;
   // Channel 0
   logic      c0_valid       = 1'b0;
   req_type_e c0_req_type    = RDLINE_I;
   cl_len_e   c0_len         = CL_1;
   cl_addr_t  c0_addr        = '0;
   logic      c0_realfull    = 1'b0;
   // Channel 1
   logic      c1_valid       = 1'b0;
   req_type_e c1_req_type    = WRLINE_I;
   cl_len_e   c1_len         = CL_1;
   logic      c1_sop         = 1'b0;
   cl_addr_t  c1_addr        = '0;
   vc_t       c1_vc          = '0;
   mdata_t    c1_mdata       = '0;
   logic      c1_realfull    = 1'b0;
   // MMIO
   logic      mmio_rd_valid  = 1'b0;
   mmio_tid_t mmio_rd_tid    = '0;
   logic      mmio_rsp_valid = 1'b0;
   mmio_tid_t mmio_rsp_tid   = '0;

   // DUT flags and their predicted values
   logic c0_illegal_type, c0_illegal_len, c0_misaligned, c0_overflow;
   logic c1_illegal_type, c1_illegal_len, c1_misaligned, c1_sop_error;
   logic c1_addr_error, c1_vc_error, c1_mdata_warn, c1_overflow;
   logic mmio_timeout, mmio_unsolicited, mmio_tid_mismatch;
   logic exp_c0_illegal_type, exp_c0_illegal_len, exp_c0_misaligned, exp_c0_overflow;
   logic exp_c1_illegal_type, exp_c1_illegal_len, exp_c1_misaligned, exp_c1_sop_error;
   logic exp_c1_addr_error, exp_c1_vc_error, exp_c1_mdata_warn, exp_c1_overflow;
   logic exp_mmio_timeout, exp_mmio_unsolicited, exp_mmio_tid_mismatch;

   // Model burst and MMIO state
   logic        ref_in_burst;
   int          ref_beat;
   int          ref_lines;
   cl_addr_t    ref_base;
   vc_t         ref_vc;
   mdata_t      ref_mdata;
   logic        ref_outstanding;
   mmio_tid_t   ref_tid;
   int          ref_wait;
   logic [15:0] lfsr_state = 16'd72;

   tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(16)) tb_clock_gen_inst (
      .clk   (clk),
      .rst_n (rst_n)
   );

   ccip_protocol_checker ccip_protocol_checker_inst (.*);

   task automatic stop_with_fail();
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at %0t ns", $time);
   endtask

   task automatic flag_mismatch(input string name);
      $display("FAILED at %0t ns: %s differs from the reference model", $time, name);
      stop_with_fail();
   endtask

   // Galois LFSR x^16+x^14+x^13+x^11+1, one step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] value;
      logic        out_bit;
      value = '0;
      for (int i = 0; i < n; i++) begin
         out_bit    = lfsr_state[0];
         value[i]   = out_bit;
         lfsr_state = lfsr_state >> 1;
         if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
         end
      end
      return value;
   endfunction

   function automatic cl_addr_t rand_addr();
      return cl_addr_t'(rand_bits(`CCIP_ADDR_WIDTH));
   endfunction

   // One cycle with every channel idle, later drives in the cycle win
   task automatic next_cycle();
      @(posedge clk);
      c0_valid       <= 1'b0;
      c1_valid       <= 1'b0;
      mmio_rd_valid  <= 1'b0;
      mmio_rsp_valid <= 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic send_c0(input req_type_e t, input cl_len_e len, input cl_addr_t addr,
                          input logic full);
      next_cycle();
      c0_valid    <= 1'b1;
      c0_req_type <= t;
      c0_len      <= len;
      c0_addr     <= addr;
      c0_realfull <= full;
   endtask

   task automatic send_c1(input req_type_e t, input cl_len_e len, input logic sop,
                          input cl_addr_t addr, input vc_t vc, input mdata_t md,
                          input logic full);
      next_cycle();
      c1_valid    <= 1'b1;
      c1_req_type <= t;
      c1_len      <= len;
      c1_sop      <= sop;
      c1_addr     <= addr;
      c1_vc       <= vc;
      c1_mdata    <= md;
      c1_realfull <= full;
   endtask

   // Well formed burst, optional fence after beat fence_after
   task automatic write_burst(input cl_len_e len, input cl_addr_t base, input int fence_after);
      vc_t    vc;
      mdata_t md;
      vc = vc_t'(rand_bits(2));
      md = mdata_t'(rand_bits(`CCIP_MDATA_WIDTH));
      for (int k = 0; k <= int'(len); k++) begin
         send_c1(WRLINE_M, len, k == 0, base + cl_addr_t'(k), vc, md, 1'b0);
         if (k + 1 == fence_after) begin
            send_c1(WRFENCE, CL_1, 1'b1, '0, vc, md, 1'b0);
         end
      end
   endtask

   task automatic send_mmio(input logic is_rsp, input mmio_tid_t tid);
      next_cycle();
      if (is_rsp) begin
         mmio_rsp_valid <= 1'b1;
         mmio_rsp_tid   <= tid;
      end else begin
         mmio_rd_valid <= 1'b1;
         mmio_rd_tid   <= tid;
      end
   endtask

   // Level sampled at the falling edge, bounded wait
   task automatic wait_for_timeout();
      for (int n = 0; n < TIMEOUT_CYCLES + 8; n++) begin
         next_cycle();
         @(negedge clk);
         if (mmio_timeout) begin
            break;
         end
      end
      if (!mmio_timeout) begin
         $display("mmio_timeout never rose while an MMIO read stayed unanswered");
         stop_with_fail();
      end
   endtask

   // Reference model, flags one cycle behind the sampled request
   always @(posedge clk) begin : reference_model
      int   c0_lines;
      int   c1_lines;
      logic c0_read;
      logic c1_write;
      logic rsp_hit;
      c0_lines = int'(c0_len) + 1;
      c1_lines = int'(c1_len) + 1;
      c0_read  = c0_req_type inside {RDLINE_I, RDLINE_S};
      c1_write = c1_valid && (c1_req_type inside {WRLINE_I, WRLINE_M});
      rsp_hit  = mmio_rsp_valid && ref_outstanding;
      if (!rst_n) begin
         {exp_c0_illegal_type, exp_c0_illegal_len, exp_c0_misaligned, exp_c0_overflow} <= '0;
         {exp_c1_illegal_type, exp_c1_illegal_len, exp_c1_misaligned, exp_c1_sop_error,
          exp_c1_addr_error, exp_c1_vc_error, exp_c1_mdata_warn, exp_c1_overflow} <= '0;
         {exp_mmio_unsolicited, exp_mmio_tid_mismatch} <= '0;
         ref_in_burst    <= 1'b0;
         ref_outstanding <= 1'b0;
         ref_wait        <= 0;
      end else begin
         exp_c0_illegal_type <= c0_valid && !c0_read;
         exp_c0_illegal_len  <= c0_valid && c0_read && (c0_lines == 3);
         // Base must be a multiple of the line count
         exp_c0_misaligned   <= c0_valid && c0_read && (c0_lines != 3) &&
                                ((c0_addr % cl_addr_t'(c0_lines)) != '0);
         exp_c0_overflow     <= c0_valid && c0_realfull;
         exp_c1_illegal_type <= c1_valid && !(c1_req_type inside {WRLINE_I, WRLINE_M, WRFENCE});
         exp_c1_overflow     <= c1_valid && c1_realfull;
         {exp_c1_illegal_len, exp_c1_misaligned, exp_c1_sop_error, exp_c1_addr_error,
          exp_c1_vc_error, exp_c1_mdata_warn} <= '0;
         if (c1_write && !ref_in_burst) begin
            if (!c1_sop) begin
               exp_c1_sop_error <= 1'b1;
            end else if (c1_lines == 3) begin
               exp_c1_illegal_len <= 1'b1;
            end else if (c1_lines > 1) begin
               exp_c1_misaligned <= (c1_addr % cl_addr_t'(c1_lines)) != '0;
               ref_in_burst      <= 1'b1;
               ref_beat          <= 2;
               ref_lines         <= c1_lines;
               ref_base          <= c1_addr;
               ref_vc            <= c1_vc;
               ref_mdata         <= c1_mdata;
            end
         end else if (c1_write) begin
            // Beat k of the burst, compared with the first beat
            exp_c1_sop_error  <= c1_sop;
            exp_c1_addr_error <= c1_addr != ref_base + cl_addr_t'(ref_beat - 1);
            exp_c1_vc_error   <= c1_vc != ref_vc;
            exp_c1_mdata_warn <= c1_mdata != ref_mdata;
            ref_beat          <= ref_beat + 1;
            if (ref_beat == ref_lines) begin
               ref_in_burst <= 1'b0;
            end
         end
         exp_mmio_unsolicited  <= mmio_rsp_valid && !ref_outstanding;
         exp_mmio_tid_mismatch <= rsp_hit && (mmio_rsp_tid != ref_tid);
         if (rsp_hit) begin
            ref_outstanding <= 1'b0;
            ref_wait        <= 0;
         end else begin
            if (mmio_rd_valid && !mmio_rsp_valid) begin
               ref_outstanding <= 1'b1;
               ref_tid         <= mmio_rd_tid;
            end
            if (ref_outstanding && (ref_wait < TIMEOUT_CYCLES)) begin
               ref_wait <= ref_wait + 1;
            end
         end
      end
   end

   assign exp_mmio_timeout = (ref_wait == TIMEOUT_CYCLES);

   assert property (@(posedge clk) disable iff (!rst_n)
      c0_illegal_type == exp_c0_illegal_type) else flag_mismatch("c0_illegal_type");
   assert property (@(posedge clk) disable iff (!rst_n)
      c0_illegal_len == exp_c0_illegal_len) else flag_mismatch("c0_illegal_len");
   assert property (@(posedge clk) disable iff (!rst_n)
      c0_misaligned == exp_c0_misaligned) else flag_mismatch("c0_misaligned");
   assert property (@(posedge clk) disable iff (!rst_n)
      c0_overflow == exp_c0_overflow) else flag_mismatch("c0_overflow");
   assert property (@(posedge clk) disable iff (!rst_n)
      c1_illegal_type == exp_c1_illegal_type) else flag_mismatch("c1_illegal_type");
   assert property (@(posedge clk) disable iff (!rst_n)
      c1_illegal_len == exp_c1_illegal_len) else flag_mismatch("c1_illegal_len");
   assert property (@(posedge clk) disable iff (!rst_n)
      c1_misaligned == exp_c1_misaligned) else flag_mismatch("c1_misaligned");
   assert property (@(posedge clk) disable iff (!rst_n)
      c1_sop_error == exp_c1_sop_error) else flag_mismatch("c1_sop_error");
   assert property (@(posedge clk) disable iff (!rst_n)
      c1_addr_error == exp_c1_addr_error) else flag_mismatch("c1_addr_error");
   assert property (@(posedge clk) disable iff (!rst_n)
      c1_vc_error == exp_c1_vc_error) else flag_mismatch("c1_vc_error");
   assert property (@(posedge clk) disable iff (!rst_n)
      c1_mdata_warn == exp_c1_mdata_warn) else flag_mismatch("c1_mdata_warn");
   assert property (@(posedge clk) disable iff (!rst_n)
      c1_overflow == exp_c1_overflow) else flag_mismatch("c1_overflow");
   assert property (@(posedge clk) disable iff (!rst_n)
      mmio_timeout == exp_mmio_timeout) else flag_mismatch("mmio_timeout");
   assert property (@(posedge clk) disable iff (!rst_n)
      mmio_unsolicited == exp_mmio_unsolicited) else flag_mismatch("mmio_unsolicited");
   assert property (@(posedge clk) disable iff (!rst_n)
      mmio_tid_mismatch == exp_mmio_tid_mismatch) else flag_mismatch("mmio_tid_mismatch");

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired, tests still running after %0d cycles", WATCHDOG_CYCLES);
      stop_with_fail();
   end

   initial begin : stimulus
      cl_addr_t  addr;
      mmio_tid_t tid;
      cl_len_e   legal_lens [3];
      legal_lens = '{CL_1, CL_2, CL_4};
      wait (rst_n === 1'b1);
      idle(2);
      // Legal traffic, no flag expected
      for (int i = 0; i < 16; i++) begin
         addr = rand_addr() & ~cl_addr_t'(3);
         send_c0(i[0] ? RDLINE_S : RDLINE_I, legal_lens[i % 3], addr, 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
         send_c1(i[0] ? WRLINE_M : WRLINE_I, CL_1, 1'b1, rand_addr(),
                 vc_t'(rand_bits(2)), mdata_t'(rand_bits(`CCIP_MDATA_WIDTH)), 1'b0);
      end
      write_burst(CL_2, rand_addr() & ~cl_addr_t'(1), 0);
      write_burst(CL_4, rand_addr() & ~cl_addr_t'(3), 2);
      write_burst(CL_4, rand_addr() & ~cl_addr_t'(3), 0);
      for (int i = 0; i < 4; i++) begin
         tid = mmio_tid_t'(rand_bits(`CCIP_TID_WIDTH));
         send_mmio(1'b0, tid);
         idle(3);
         send_mmio(1'b1, tid);
      end
      // C0 bad types, some with CL_3 and odd addresses on top
      for (int t = 2; t < 16; t++) begin
         send_c0(req_type_e'(4'(t)), CL_3, rand_addr(), 1'b0);
      end
      repeat (3) send_c0(RDLINE_I, CL_3, rand_addr(), 1'b0);
      send_c0(RDLINE_S, CL_2, rand_addr() | cl_addr_t'(1), 1'b0);
      for (int i = 1; i < 4; i++) begin
         send_c0(RDLINE_I, CL_4, (rand_addr() & ~cl_addr_t'(3)) | cl_addr_t'(i), 1'b0);
      end
      // C1 first-beat faults
      send_c1(WRLINE_I, CL_1, 1'b0, rand_addr(), 2'd0, 16'h0, 1'b0);
      send_c1(WRLINE_M, CL_2, 1'b0, rand_addr(), 2'd1, 16'h0, 1'b0);
      send_c1(WRLINE_I, CL_3, 1'b1, rand_addr(), 2'd2, 16'h0, 1'b0);
      send_c1(RDLINE_I, CL_1, 1'b1, rand_addr(), 2'd0, 16'h0, 1'b0);
      send_c1(req_type_e'(4'hA), CL_1, 1'b1, rand_addr(), 2'd0, 16'h0, 1'b0);
      // Misaligned bases, bursts still tracked from the base
      write_burst(CL_4, (rand_addr() & ~cl_addr_t'(3)) | cl_addr_t'(2), 0);
      write_burst(CL_2, rand_addr() | cl_addr_t'(1), 0);
      // Later-beat faults, SOP then address then VC
      addr = rand_addr() & ~cl_addr_t'(3);
      send_c1(WRLINE_I, CL_4, 1'b1, addr, 2'd2, 16'h1234, 1'b0);
      send_c1(WRLINE_I, CL_4, 1'b1, addr + cl_addr_t'(1), 2'd2, 16'h1234, 1'b0);
      send_c1(WRLINE_I, CL_4, 1'b0, addr + cl_addr_t'(5), 2'd2, 16'h1234, 1'b0);
      send_c1(WRLINE_I, CL_4, 1'b0, addr + cl_addr_t'(3), 2'd3, 16'h1234, 1'b0);
      send_c1(WRLINE_M, CL_2, 1'b1, addr, 2'd1, 16'h00FF, 1'b0);
      send_c1(WRLINE_M, CL_2, 1'b0, addr + cl_addr_t'(1), 2'd1, 16'h01FF, 1'b0);
      write_burst(CL_4, rand_addr() & ~cl_addr_t'(3), 3);
      // MMIO TID mismatch, unsolicited response, then timeout
      tid = mmio_tid_t'(rand_bits(`CCIP_TID_WIDTH));
      send_mmio(1'b0, tid);
      idle(2);
      send_mmio(1'b1, tid ^ mmio_tid_t'(1));
      idle(2);
      send_mmio(1'b1, mmio_tid_t'(rand_bits(`CCIP_TID_WIDTH)));
      idle(2);
      send_mmio(1'b0, tid);
      wait_for_timeout();
      idle(6);
      send_mmio(1'b1, tid);
      idle(3);
      // Requests into a full port, then the same with room
      for (int i = 0; i < 4; i++) begin
         send_c0(RDLINE_I, CL_1, rand_addr(), i < 2);
         send_c1(WRLINE_I, CL_1, 1'b1, rand_addr(), 2'd0, 16'h0, i < 2);
      end
      idle(4);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * Free running clock, active-low reset held for a set number of cycles
 */

module tb_clock_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

   // Released on a rising edge like every other input
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule
